//--- fpu_ss_pkg.sv
/*
  shared types for the single-precision coprocessor subset
  only sign injection, fmv, flw/fsw and frm access are decoded
  instruction ids are 4 bits wide and simply echoed back to the core
*/
package fpu_ss_pkg;

  // plain widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  instr_id_t;
  typedef logic [2:0]  frm_t;

  // major opcodes
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // funct7 for OP-FP
  localparam logic [6:0] F7_FSGNJ   = 7'b0010000;
  localparam logic [6:0] F7_FMV_X_W = 7'b1110000;
  localparam logic [6:0] F7_FMV_W_X = 7'b1111000;

  // funct3 values
  localparam logic [2:0] F3_SGNJ  = 3'b000;
  localparam logic [2:0] F3_SGNJN = 3'b001;
  localparam logic [2:0] F3_SGNJX = 3'b010;
  localparam logic [2:0] F3_FMV   = 3'b000;
  localparam logic [2:0] F3_WORD  = 3'b010;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  // rounding mode CSR
  localparam logic [11:0] CSR_FRM = 12'h002;

  typedef enum logic [3:0] {
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MV_W_X,
    OP_MV_X_W,
    OP_LOAD,
    OP_STORE,
    OP_CSRRW,
    OP_CSRRS
  } op_e;

  typedef enum logic [1:0] {
    IDLE,
    MEM_REQ,
    MEM_WAIT,
    RESULT
  } ctrl_state_e;

  // one buffered instruction after decode
  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
    word_t     int_op;
    instr_id_t id;
  } decoded_instr_t;

  // eXtension interface channels
  typedef struct packed {
    word_t     instr;
    word_t     rs;
    instr_id_t id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  typedef struct packed {
    word_t     addr;
    logic      we;
    word_t     wdata;
    instr_id_t id;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } mem_result_t;

  typedef struct packed {
    instr_id_t id;
    reg_addr_t rd;
    word_t     data;
    logic      we;
  } result_t;

endpackage

//--- fpu_ss_decoder.sv
/*
  purely combinational issue decoder
  the response is only meaningful while the issue handshake completes
  anything outside the kept subset is rejected with accept low
*/
`timescale 1ns/1ns

module fpu_ss_decoder import fpu_ss_pkg::*; (
  input  issue_req_t     issue_req_i,
  output issue_resp_t    issue_resp_o,
  output decoded_instr_t decoded_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] csr_addr;
  word_t       imm_i;
  word_t       imm_s;

  // instruction fields
  assign opcode   = issue_req_i.instr[6:0];
  assign funct3   = issue_req_i.instr[14:12];
  assign funct7   = issue_req_i.instr[31:25];
  assign csr_addr = issue_req_i.instr[31:20];

  // sign-extended immediates for flw and fsw
  assign imm_i = {{20{issue_req_i.instr[31]}}, issue_req_i.instr[31:20]};
  assign imm_s = {{20{issue_req_i.instr[31]}}, issue_req_i.instr[31:25],
                  issue_req_i.instr[11:7]};

  always_comb begin
    decoded_o.op     = OP_SGNJ;
    decoded_o.rd     = issue_req_i.instr[11:7];
    decoded_o.rs1    = issue_req_i.instr[19:15];
    decoded_o.rs2    = issue_req_i.instr[24:20];
    decoded_o.imm    = imm_i;
    decoded_o.int_op = issue_req_i.rs;
    decoded_o.id     = issue_req_i.id;
    issue_resp_o     = '0;

    case (opcode)
      OPC_OP_FP: begin
        if (funct7 == F7_FSGNJ) begin
          // sign injection variants share funct7
          issue_resp_o.accept = 1'b1;
          case (funct3)
            F3_SGNJ:  decoded_o.op = OP_SGNJ;
            F3_SGNJN: decoded_o.op = OP_SGNJN;
            F3_SGNJX: decoded_o.op = OP_SGNJX;
            default:  issue_resp_o.accept = 1'b0;
          endcase
        end else if (funct3 == F3_FMV && decoded_o.rs2 == reg_addr_t'(0)) begin
          if (funct7 == F7_FMV_X_W) begin
            // float to integer register, result goes back to the core
            decoded_o.op           = OP_MV_X_W;
            issue_resp_o.accept    = 1'b1;
            issue_resp_o.writeback = 1'b1;
          end else if (funct7 == F7_FMV_W_X) begin
            decoded_o.op        = OP_MV_W_X;
            issue_resp_o.accept = 1'b1;
          end
        end
      end
      OPC_LOAD_FP: begin
        if (funct3 == F3_WORD) begin
          decoded_o.op           = OP_LOAD;
          issue_resp_o.accept    = 1'b1;
          issue_resp_o.loadstore = 1'b1;
        end
      end
      OPC_STORE_FP: begin
        if (funct3 == F3_WORD) begin
          decoded_o.op           = OP_STORE;
          decoded_o.imm          = imm_s;
          issue_resp_o.accept    = 1'b1;
          issue_resp_o.loadstore = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        // only frm lives here, fflags and fcsr are not offered
        if (csr_addr == CSR_FRM && (funct3 == F3_CSRRW || funct3 == F3_CSRRS)) begin
          decoded_o.op           = (funct3 == F3_CSRRS) ? OP_CSRRS : OP_CSRRW;
          issue_resp_o.accept    = 1'b1;
          issue_resp_o.writeback = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- fpu_ss_in_fifo.sv
/*
  circular buffer for decoded instructions
  no fall-through, a pushed entry shows at pop one cycle later
  DEPTH must be at least 1
*/
`timescale 1ns/1ns

module fpu_ss_in_fifo import fpu_ss_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_valid_i,
  output logic           push_ready_o,
  input  decoded_instr_t push_data_i,
  output logic           pop_valid_o,
  input  logic           pop_ready_i,
  output decoded_instr_t pop_data_o
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  decoded_instr_t mem [DEPTH];
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [CW-1:0]  count_q;
  logic           push_fire;
  logic           pop_fire;

  assign push_ready_o = (count_q != CW'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem[rd_ptr_q];
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  // storage only, contents are qualified by count
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap at DEPTH, which need not be a power of two
      if (push_fire) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- fpu_ss_regfile.sv
/*
  32 x 32-bit float registers, cleared on reset
  f0 is an ordinary register, not hardwired to zero
  reads are combinational, the write lands on the clock edge
*/
`timescale 1ns/1ns

module fpu_ss_regfile import fpu_ss_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i
);

  word_t regs_q [32];

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- fpu_ss_csr.sv
/*
  rounding mode register frm
  csrrw replaces frm, csrrs ORs bits in, upper write bits are dropped
  the read value is the state before the current write
*/
`timescale 1ns/1ns

module fpu_ss_csr import fpu_ss_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  csr_we_i,
  input  logic  csr_set_i,
  input  word_t csr_wdata_i,
  output word_t csr_rdata_o,
  output frm_t  frm_o
);

  frm_t frm_q;
  frm_t frm_d;

  // zero-extended read of the current mode
  assign csr_rdata_o = {29'b0, frm_q};
  assign frm_o       = frm_q;

  always_comb begin
    frm_d = frm_q;
    if (csr_we_i) begin
      // set mode keeps the old bits
      if (csr_set_i) begin
        frm_d = frm_q | csr_wdata_i[2:0];
      end else begin
        frm_d = csr_wdata_i[2:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      frm_q <= '0;
    end else begin
      frm_q <= frm_d;
    end
  end

endmodule

//--- fpu_ss_controller.sv
/*
  in-order executor behind the input buffer, one instruction at a time
  register ops and fmv.w.x complete on the pop cycle
  fmv.x.w and CSR ops present a result the cycle after the pop
  flw and fsw issue one memory request, a load then waits for its data
*/
`timescale 1ns/1ns

module fpu_ss_controller import fpu_ss_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,

  // buffer pop side
  input  logic           pop_valid_i,
  output logic           pop_ready_o,
  input  decoded_instr_t instr_i,

  // register file
  output reg_addr_t      rf_raddr_a_o,
  output reg_addr_t      rf_raddr_b_o,
  input  word_t          rf_rdata_a_i,
  input  word_t          rf_rdata_b_i,
  output reg_addr_t      rf_waddr_o,
  output word_t          rf_wdata_o,
  output logic           rf_we_o,

  // frm CSR
  output logic           csr_we_o,
  output logic           csr_set_o,
  output word_t          csr_wdata_o,
  input  word_t          csr_rdata_i,

  // memory request channel
  output logic           x_mem_valid_o,
  input  logic           x_mem_ready_i,
  output mem_req_t       x_mem_req_o,

  // memory result channel
  input  logic           x_mem_result_valid_i,
  input  mem_result_t    x_mem_result_i,

  // result channel
  output logic           x_result_valid_o,
  input  logic           x_result_ready_i,
  output result_t        x_result_o
);

  ctrl_state_e    state_q;
  ctrl_state_e    state_d;
  decoded_instr_t instr_q;
  mem_req_t       mem_req_q;
  result_t        result_q;
  logic           pop_fire;
  logic           is_csr;
  logic           sgnj_sign;
  word_t          sgnj_result;

  // only the idle state takes a new instruction
  assign pop_ready_o = (state_q == IDLE);
  assign pop_fire    = pop_valid_i & pop_ready_o;
  assign is_csr      = (instr_i.op == OP_CSRRW) || (instr_i.op == OP_CSRRS);

  // operands are read straight from the buffer head
  assign rf_raddr_a_o = instr_i.rs1;
  assign rf_raddr_b_o = instr_i.rs2;

  // sign injection keeps magnitude of rs1
  always_comb begin
    case (instr_i.op)
      OP_SGNJN: sgnj_sign = ~rf_rdata_b_i[31];
      OP_SGNJX: sgnj_sign = rf_rdata_a_i[31] ^ rf_rdata_b_i[31];
      default:  sgnj_sign = rf_rdata_b_i[31];
    endcase
  end

  assign sgnj_result = {sgnj_sign, rf_rdata_a_i[30:0]};

  // register file write port
  always_comb begin
    rf_we_o    = 1'b0;
    rf_waddr_o = instr_i.rd;
    rf_wdata_o = sgnj_result;
    if (pop_fire) begin
      case (instr_i.op)
        OP_SGNJ, OP_SGNJN, OP_SGNJX: rf_we_o = 1'b1;
        OP_MV_W_X: begin
          rf_we_o    = 1'b1;
          rf_wdata_o = instr_i.int_op;
        end
        default: ;
      endcase
    end else if (state_q == MEM_WAIT && x_mem_result_valid_i) begin
      // load data goes to the latched destination
      rf_we_o    = 1'b1;
      rf_waddr_o = instr_q.rd;
      rf_wdata_o = x_mem_result_i.rdata;
    end
  end

  // CSR access happens on the pop cycle, old value is captured then
  assign csr_we_o    = pop_fire & is_csr;
  assign csr_set_o   = (instr_i.op == OP_CSRRS);
  assign csr_wdata_o = instr_i.int_op;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (pop_fire) begin
          case (instr_i.op)
            OP_MV_X_W, OP_CSRRW, OP_CSRRS: state_d = RESULT;
            OP_LOAD, OP_STORE:             state_d = MEM_REQ;
            default: ;
          endcase
        end
      end
      MEM_REQ: begin
        if (x_mem_ready_i) begin
          state_d = (instr_q.op == OP_STORE) ? IDLE : MEM_WAIT;
        end
      end
      MEM_WAIT: begin
        if (x_mem_result_valid_i) begin
          state_d = IDLE;
        end
      end
      RESULT: begin
        if (x_result_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // channel payloads, loaded on every pop and held until the next one
  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      instr_q         <= instr_i;
      mem_req_q.addr  <= instr_i.int_op + instr_i.imm;
      mem_req_q.we    <= (instr_i.op == OP_STORE);
      mem_req_q.wdata <= rf_rdata_b_i;
      mem_req_q.id    <= instr_i.id;
      result_q.id     <= instr_i.id;
      result_q.rd     <= instr_i.rd;
      result_q.we     <= 1'b1;
      result_q.data   <= is_csr ? csr_rdata_i : rf_rdata_a_i;
    end
  end

  assign x_mem_valid_o    = (state_q == MEM_REQ);
  assign x_mem_req_o      = mem_req_q;
  assign x_result_valid_o = (state_q == RESULT);
  assign x_result_o       = result_q;

endmodule

//--- fpu_ss.sv
/*
  floating-point coprocessor subset on the eXtension interface
  accepted instructions are committed at once, there is no commit channel
  issue_ready follows the input buffer fill level only
  frm is held for a future arithmetic unit and has no consumer yet
*/
`timescale 1ns/1ns

module fpu_ss import fpu_ss_pkg::*; #(
  parameter int unsigned IN_FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // issue channel
  input  logic        x_issue_valid_i,
  output logic        x_issue_ready_o,
  input  issue_req_t  x_issue_req_i,
  output issue_resp_t x_issue_resp_o,

  // memory request channel
  output logic        x_mem_valid_o,
  input  logic        x_mem_ready_i,
  output mem_req_t    x_mem_req_o,

  // memory result channel
  input  logic        x_mem_result_valid_i,
  input  mem_result_t x_mem_result_i,

  // result channel
  output logic        x_result_valid_o,
  input  logic        x_result_ready_i,
  output result_t     x_result_o
);

  decoded_instr_t decoded_push;
  decoded_instr_t decoded_pop;
  logic           push_valid;
  logic           pop_valid;
  logic           pop_ready;
  reg_addr_t      rf_raddr_a;
  reg_addr_t      rf_raddr_b;
  word_t          rf_rdata_a;
  word_t          rf_rdata_b;
  reg_addr_t      rf_waddr;
  word_t          rf_wdata;
  logic           rf_we;
  logic           csr_we;
  logic           csr_set;
  word_t          csr_wdata;
  word_t          csr_rdata;

  // rejected instructions finish the handshake but are never buffered
  assign push_valid = x_issue_valid_i & x_issue_resp_o.accept;

  fpu_ss_decoder fpu_ss_decoder_i (
    .issue_req_i  (x_issue_req_i),
    .issue_resp_o (x_issue_resp_o),
    .decoded_o    (decoded_push)
  );

  fpu_ss_in_fifo #(
    .DEPTH (IN_FIFO_DEPTH)
  ) fpu_ss_in_fifo_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (push_valid),
    .push_ready_o (x_issue_ready_o),
    .push_data_i  (decoded_push),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (pop_ready),
    .pop_data_o   (decoded_pop)
  );

  fpu_ss_regfile fpu_ss_regfile_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  // frm output stays open until an arithmetic unit is added
  fpu_ss_csr fpu_ss_csr_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we_i    (csr_we),
    .csr_set_i   (csr_set),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .frm_o       ()
  );

  fpu_ss_controller fpu_ss_controller_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .pop_valid_i          (pop_valid),
    .pop_ready_o          (pop_ready),
    .instr_i              (decoded_pop),
    .rf_raddr_a_o         (rf_raddr_a),
    .rf_raddr_b_o         (rf_raddr_b),
    .rf_rdata_a_i         (rf_rdata_a),
    .rf_rdata_b_i         (rf_rdata_b),
    .rf_waddr_o           (rf_waddr),
    .rf_wdata_o           (rf_wdata),
    .rf_we_o              (rf_we),
    .csr_we_o             (csr_we),
    .csr_set_o            (csr_set),
    .csr_wdata_o          (csr_wdata),
    .csr_rdata_i          (csr_rdata),
    .x_mem_valid_o        (x_mem_valid_o),
    .x_mem_ready_i        (x_mem_ready_i),
    .x_mem_req_o          (x_mem_req_o),
    .x_mem_result_valid_i (x_mem_result_valid_i),
    .x_mem_result_i       (x_mem_result_i),
    .x_result_valid_o     (x_result_valid_o),
    .x_result_ready_i     (x_result_ready_i),
    .x_result_o           (x_result_o)
  );

endmodule

//--- tb_fpu_ss_assertions.sv
/*
  handshake checks bound into fpu_ss
  memory request and result must hold while the consumer stalls
  no valid may be high in the first cycle after reset release
*/
`timescale 1ns/1ns

module tb_fpu_ss_assertions import fpu_ss_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     mem_valid_i,
  input logic     mem_ready_i,
  input mem_req_t mem_req_i,
  input logic     result_valid_i,
  input logic     result_ready_i,
  input result_t  result_i
);

  // failure count, picked up by the testbench at the end of the run
  int failures = 0;

  // stalled memory request keeps valid and payload
  mem_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i))
    else begin
      $error("memory request dropped or changed while stalled");
      failures++;
    end

  // same rule on the result channel
  result_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
    else begin
      $error("result dropped or changed while stalled");
      failures++;
    end

  reset_quiet_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !mem_valid_i && !result_valid_i)
    else begin
      $error("valid high right after reset release");
      failures++;
    end

endmodule

bind fpu_ss tb_fpu_ss_assertions handshake_checks_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .mem_valid_i    (x_mem_valid_o),
  .mem_ready_i    (x_mem_ready_i),
  .mem_req_i      (x_mem_req_o),
  .result_valid_i (x_result_valid_o),
  .result_ready_i (x_result_ready_i),
  .result_i       (x_result_o)
);

//--- tb_fpu_ss.sv
/*
  table-driven testbench for the fpu_ss coprocessor subset
  inputs change on the falling edge and transfers are recorded there as well
  the memory model answers a load two cycles after the request transfer
  both ready inputs stall at random with a fixed seed
*/
`timescale 1ns/1ns

module tb_fpu_ss import fpu_ss_pkg::*; ();

  localparam int TIMEOUT = 200;

  // what a table entry is expected to produce
  localparam logic [2:0] K_NONE   = 3'd0;
  localparam logic [2:0] K_RESULT = 3'd1;
  localparam logic [2:0] K_LOAD   = 3'd2;
  localparam logic [2:0] K_STORE  = 3'd3;
  localparam logic [2:0] K_REJECT = 3'd4;

  // major opcodes and funct7 codes used to build instructions
  localparam logic [6:0] OPFP    = 7'b1010011;
  localparam logic [6:0] LOADFP  = 7'b0000111;
  localparam logic [6:0] STOREFP = 7'b0100111;
  localparam logic [6:0] SYSTEM  = 7'b1110011;
  localparam logic [6:0] OPINT   = 7'b0110011;
  localparam logic [6:0] FMVWX   = 7'b1111000;
  localparam logic [6:0] FMVXW   = 7'b1110000;
  localparam logic [6:0] FSGNJ   = 7'b0010000;
  localparam logic [6:0] FDIV    = 7'b0001100;

  typedef struct packed {
    logic [2:0] kind;
    word_t      instr;
    word_t      rs;
    instr_id_t  id;
    logic       accept;
    reg_addr_t  rd;
    word_t      data;
    word_t      addr;
    word_t      wdata;
    word_t      load;
  } test_t;

  logic        clk_i;
  logic        rst_ni;
  logic        x_issue_valid_i;
  logic        x_issue_ready_o;
  issue_req_t  x_issue_req_i;
  issue_resp_t x_issue_resp_o;
  logic        x_mem_valid_o;
  logic        x_mem_ready_i;
  mem_req_t    x_mem_req_o;
  logic        x_mem_result_valid_i;
  mem_result_t x_mem_result_i;
  logic        x_result_valid_o;
  logic        x_result_ready_i;
  result_t     x_result_o;

  test_t    tests[$];
  result_t  res_q[$];
  mem_req_t mem_q[$];
  integer   seed;
  int       errors;
  int       passed;
  int       load_delay = 0;
  word_t    load_data;
  bit       timed_out;

  fpu_ss #(
    .IN_FIFO_DEPTH (4)
  ) fpu_ss_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .x_issue_valid_i      (x_issue_valid_i),
    .x_issue_ready_o      (x_issue_ready_o),
    .x_issue_req_i        (x_issue_req_i),
    .x_issue_resp_o       (x_issue_resp_o),
    .x_mem_valid_o        (x_mem_valid_o),
    .x_mem_ready_i        (x_mem_ready_i),
    .x_mem_req_o          (x_mem_req_o),
    .x_mem_result_valid_i (x_mem_result_valid_i),
    .x_mem_result_i       (x_mem_result_i),
    .x_result_valid_o     (x_result_valid_o),
    .x_result_ready_i     (x_result_ready_i),
    .x_result_o           (x_result_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // memory model and ready stalls run on the falling edge
  always @(negedge clk_i) begin
    x_mem_result_valid_i = 1'b0;
    if (load_delay > 0) begin
      load_delay = load_delay - 1;
      if (load_delay == 0) begin
        // one-cycle load answer
        x_mem_result_valid_i  = 1'b1;
        x_mem_result_i.rdata = load_data;
        x_mem_result_i.err   = 1'b0;
      end
    end
    // readies low about one cycle in four
    x_mem_ready_i    = (($random(seed) & 3) != 0);
    x_result_ready_i = (($random(seed) & 3) != 0);
    // valid and payload hold until the next rising edge so the transfer is known here
    if (x_mem_valid_o && x_mem_ready_i) begin
      mem_q.push_back(x_mem_req_o);
      if (!x_mem_req_o.we) begin
        load_delay = 2;
      end
    end
    if (x_result_valid_o && x_result_ready_i) begin
      res_q.push_back(x_result_o);
    end
  end

  // OP-FP R-type word
  function automatic word_t fp_op(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPFP};
  endfunction

  function automatic string kind_name(input logic [2:0] kind);
    case (kind)
      K_NONE:   return "register op";
      K_RESULT: return "result";
      K_LOAD:   return "flw";
      K_STORE:  return "fsw";
      default:  return "reject";
    endcase
  endfunction

  task automatic add_test(input logic [2:0] kind, input word_t instr, input word_t rs,
                          input instr_id_t id, input logic accept, input reg_addr_t rd,
                          input word_t data, input word_t addr, input word_t wdata,
                          input word_t load);
    test_t t;
    t = {kind, instr, rs, id, accept, rd, data, addr, wdata, load};
    tests.push_back(t);
  endtask

  task automatic build_table();
    // f1 = 1.5 and read back through x5
    add_test(K_NONE, fp_op(FMVWX, 5'd0, 5'd10, 3'b000, 5'd1), 32'h3fc0_0000, 4'd1, 1'b1,
             5'd1, '0, '0, '0, '0);
    add_test(K_RESULT, fp_op(FMVXW, 5'd0, 5'd1, 3'b000, 5'd5), '0, 4'd2, 1'b1,
             5'd5, 32'h3fc0_0000, '0, '0, '0);
    // f2 = -10.0
    add_test(K_NONE, fp_op(FMVWX, 5'd0, 5'd11, 3'b000, 5'd2), 32'hc120_0000, 4'd3, 1'b1,
             5'd2, '0, '0, '0, '0);
    // f3 = magnitude of f1 with the sign of f2
    add_test(K_NONE, fp_op(FSGNJ, 5'd2, 5'd1, 3'b000, 5'd3), '0, 4'd4, 1'b1,
             5'd3, '0, '0, '0, '0);
    // f4 gets the inverted sign of f2 and turns positive
    add_test(K_NONE, fp_op(FSGNJ, 5'd2, 5'd1, 3'b001, 5'd4), '0, 4'd5, 1'b1,
             5'd4, '0, '0, '0, '0);
    // positive f1 xor negative f2 gives a negative f5
    add_test(K_NONE, fp_op(FSGNJ, 5'd2, 5'd1, 3'b010, 5'd5), '0, 4'd6, 1'b1,
             5'd5, '0, '0, '0, '0);
    add_test(K_RESULT, fp_op(FMVXW, 5'd0, 5'd3, 3'b000, 5'd6), '0, 4'd7, 1'b1,
             5'd6, 32'hbfc0_0000, '0, '0, '0);
    add_test(K_RESULT, fp_op(FMVXW, 5'd0, 5'd4, 3'b000, 5'd7), '0, 4'd8, 1'b1,
             5'd7, 32'h3fc0_0000, '0, '0, '0);
    add_test(K_RESULT, fp_op(FMVXW, 5'd0, 5'd5, 3'b000, 5'd8), '0, 4'd9, 1'b1,
             5'd8, 32'hbfc0_0000, '0, '0, '0);
    // flw f7, -4(x10) with x10 = 0x1000
    add_test(K_LOAD, {12'hffc, 5'd10, 3'b010, 5'd7, LOADFP}, 32'h0000_1000, 4'd10, 1'b1,
             5'd7, '0, 32'h0000_0ffc, '0, 32'h1234_5678);
    add_test(K_RESULT, fp_op(FMVXW, 5'd0, 5'd7, 3'b000, 5'd9), '0, 4'd11, 1'b1,
             5'd9, 32'h1234_5678, '0, '0, '0);
    // fsw f3, -8(x11) with the offset split into 7'h7f and 5'h18
    add_test(K_STORE, {7'h7f, 5'd3, 5'd11, 3'b010, 5'h18, STOREFP}, 32'h2000_0000, 4'd12,
             1'b1, 5'd0, '0, 32'h1fff_fff8, 32'hbfc0_0000, '0);
    // csrrw x12, frm, x13 keeps 3'b101 and returns the reset value
    add_test(K_RESULT, {12'h002, 5'd13, 3'b001, 5'd12, SYSTEM}, 32'hffff_fffd, 4'd13, 1'b1,
             5'd12, 32'h0, '0, '0, '0);
    // csrrs sets bit 1 on top of 3'b101
    add_test(K_RESULT, {12'h002, 5'd14, 3'b010, 5'd14, SYSTEM}, 32'h0000_0002, 4'd14, 1'b1,
             5'd14, 32'h5, '0, '0, '0);
    add_test(K_RESULT, {12'h002, 5'd0, 3'b010, 5'd16, SYSTEM}, '0, 4'd15, 1'b1,
             5'd16, 32'h7, '0, '0, '0);
    // fdiv.s and an integer add are not offered
    add_test(K_REJECT, fp_op(FDIV, 5'd2, 5'd1, 3'b000, 5'd1), '0, 4'd0, 1'b0,
             5'd1, '0, '0, '0, '0);
    add_test(K_REJECT, {7'b0, 5'd3, 5'd2, 3'b000, 5'd1, OPINT}, 32'h0000_00ff, 4'd1, 1'b0,
             5'd1, '0, '0, '0, '0);
    // f1 still 1.5 after the rejected fdiv
    add_test(K_RESULT, fp_op(FMVXW, 5'd0, 5'd1, 3'b000, 5'd15), '0, 4'd2, 1'b1,
             5'd15, 32'h3fc0_0000, '0, '0, '0);
  endtask

  task automatic compare(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic bit queue_empty(input bit mem_side);
    return mem_side ? (mem_q.size() == 0) : (res_q.size() == 0);
  endfunction

  // hold the issue request until ready and sample the response mid-cycle
  task automatic issue(input test_t t, output issue_resp_t resp);
    int waited;
    waited = 0;
    @(negedge clk_i);
    x_issue_valid_i     = 1'b1;
    x_issue_req_i.instr = t.instr;
    x_issue_req_i.rs    = t.rs;
    x_issue_req_i.id    = t.id;
    #1;
    while (!x_issue_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    resp = x_issue_resp_o;
    if (!x_issue_ready_o) begin
      $display("timeout: issue of instruction %h was never taken", t.instr);
      timed_out = 1'b1;
    end
    @(negedge clk_i);
    x_issue_valid_i = 1'b0;
  endtask

  task automatic wait_transfer(input bit mem_side);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (queue_empty(mem_side) && waited < TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (queue_empty(mem_side)) begin
      $display("timeout: no %s transfer within %0d cycles",
               mem_side ? "memory request" : "result", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // anything left over came from an instruction that should have stayed quiet
  task automatic check_no_extra(input int idx);
    if (res_q.size() != 0 || mem_q.size() != 0) begin
      $display("test %0d: %0d unexpected result and %0d unexpected memory transfers",
               idx, res_q.size(), mem_q.size());
      errors++;
      res_q.delete();
      mem_q.delete();
    end
  endtask

  task automatic run_test(input int idx, input test_t t);
    int          errors_before;
    issue_resp_t resp;
    result_t     res;
    mem_req_t    req;
    errors_before = errors;
    if (t.kind == K_LOAD) begin
      load_data = t.load;
    end
    issue(t, resp);
    if (!timed_out) begin
      compare("x_issue_resp_o.accept", word_t'(resp.accept), word_t'(t.accept));
      if (t.accept) begin
        compare("x_issue_resp_o.writeback", word_t'(resp.writeback),
                word_t'(t.kind == K_RESULT));
        compare("x_issue_resp_o.loadstore", word_t'(resp.loadstore),
                word_t'(t.kind == K_LOAD || t.kind == K_STORE));
      end
      if (t.kind == K_RESULT) begin
        wait_transfer(1'b0);
        if (!timed_out) begin
          res = res_q.pop_front();
          compare("x_result_o.id", word_t'(res.id), word_t'(t.id));
          compare("x_result_o.rd", word_t'(res.rd), word_t'(t.rd));
          compare("x_result_o.data", res.data, t.data);
          compare("x_result_o.we", word_t'(res.we), 32'd1);
          check_no_extra(idx);
        end
      end else if (t.kind == K_LOAD || t.kind == K_STORE) begin
        wait_transfer(1'b1);
        if (!timed_out) begin
          req = mem_q.pop_front();
          compare("x_mem_req_o.addr", req.addr, t.addr);
          compare("x_mem_req_o.we", word_t'(req.we), word_t'(t.kind == K_STORE));
          compare("x_mem_req_o.id", word_t'(req.id), word_t'(t.id));
          if (t.kind == K_STORE) begin
            compare("x_mem_req_o.wdata", req.wdata, t.wdata);
          end
          check_no_extra(idx);
        end
      end
    end
    if (errors == errors_before && !timed_out) begin
      passed++;
      $display("test %0d %s: pass", idx, kind_name(t.kind));
    end else begin
      $display("test %0d %s: fail", idx, kind_name(t.kind));
    end
  endtask

  initial begin
    seed                 = 35;
    errors               = 0;
    passed               = 0;
    timed_out            = 1'b0;
    load_data            = '0;
    rst_ni               = 1'b0;
    x_issue_valid_i      = 1'b0;
    x_issue_req_i        = '0;
    x_mem_ready_i        = 1'b1;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_i       = '0;
    x_result_ready_i     = 1'b1;
    build_table();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // the empty buffer takes issues right after reset
    compare("x_issue_ready_o", word_t'(x_issue_ready_o), 32'd1);
    for (int i = 0; i < tests.size(); i++) begin
      run_test(i, tests[i]);
      if (timed_out) begin
        break;
      end
    end
    if (!timed_out) begin
      check_no_extra(tests.size());
    end
    if (fpu_ss_i.handshake_checks_i.failures != 0) begin
      $display("%0d handshake assertions failed", fpu_ss_i.handshake_checks_i.failures);
      errors += fpu_ss_i.handshake_checks_i.failures;
    end
    $display("%0d of %0d tests passed, %0d errors", passed, tests.size(), errors);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
fpu_ss_pkg.sv
fpu_ss_decoder.sv
fpu_ss_in_fifo.sv
fpu_ss_regfile.sv
fpu_ss_csr.sv
fpu_ss_controller.sv
fpu_ss.sv
tb_fpu_ss_assertions.sv
tb_fpu_ss.sv

//--- run.sh
#!/bin/sh
# build the fpu_ss testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpu_ss -f project.f -o sim_fpu_ss
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# a high error limit lets assertion failures reach the testbench summary
output=$(./obj_dir/sim_fpu_ss +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
